//--- verilog/lpif_link_macros.svh
////////////////////////////////////////
// Widths and bit positions of the LPIF link word and PHY channels
// Include wherever a field slice or channel bit is addressed
////////////////////////////////////////
`ifndef LPIF_LINK_MACROS_SVH
`define LPIF_LINK_MACROS_SVH

// Link word and PHY channel
`define LL_WORD_W     150
`define LL_PHY_W      80
`define LL_SLICE_W    75
`define LL_STB_BIT    75
`define LL_MRK_BIT    76
`define LL_DLY_W      16

// LPIF field widths
`define LL_STATE_W    8
`define LL_PROTID_W   4
`define LL_DATA_W     128
`define LL_DVALID_W   2
`define LL_CRC_W      4
`define LL_CRCV_W     2
`define LL_VALID_W    2

// Field LSBs in the link word, low bit up
`define LL_STATE_LSB  0
`define LL_PROTID_LSB 8
`define LL_DATA_LSB   12
`define LL_DVALID_LSB 140
`define LL_CRC_LSB    142
`define LL_CRCV_LSB   146
`define LL_VALID_LSB  148

`endif

//--- verilog/lpif_link_pkg.sv
////////////////////////////////////////
// Shared types for the LPIF x2 master link
// Import into any module using link words or delays
////////////////////////////////////////
`default_nettype none
`include "lpif_link_macros.svh"

package lpif_link_pkg;

  ////////////////////////////////////////
  // Link and PHY vectors
  ////////////////////////////////////////

  // Full logic-link word, state in the low bits
  typedef logic [`LL_WORD_W-1:0]   ll_word_t;

  // One AIB channel
  typedef logic [`LL_PHY_W-1:0]    phy_word_t;

  ////////////////////////////////////////
  // LPIF fields
  ////////////////////////////////////////

  typedef logic [`LL_STATE_W-1:0]  lp_state_t;
  typedef logic [`LL_PROTID_W-1:0] lp_protid_t;
  typedef logic [`LL_DATA_W-1:0]   lp_data_t;

  // Word-alignment delay count
  typedef logic [`LL_DLY_W-1:0]    dly_t;

  // Per-direction online sequencing
  typedef enum logic [1:0] {
    SYNC_OFFLINE = 2'd0,
    SYNC_WAIT    = 2'd1,
    SYNC_ONLINE  = 2'd2
  } sync_state_t;

endpackage

`default_nettype wire

//--- verilog/lpif_auto_sync.sv
////////////////////////////////////////
// Online delay sequencing for both link directions
// Also drives the per-word strobe and alternating marker bits
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module lpif_auto_sync
  import lpif_link_pkg::*;
(
  input  logic clk_wr,
  input  logic rst_n,

  // Raw online requests
  input  logic tx_online,
  input  logic rx_online,

  // Word-alignment times
  input  dly_t delay_x_value,
  input  dly_t delay_y_value,
  input  dly_t delay_z_value,

  // Delayed online and alignment bits
  output logic tx_online_delay,
  output logic rx_online_delay,
  output logic tx_stb_bit,
  output logic tx_mrk_bit
);

  ////////////////////////////////////////
  // Shared step functions
  ////////////////////////////////////////

  // Next state for one direction
  function automatic sync_state_t sync_next(
    sync_state_t cur,
    logic        go,
    dly_t        cnt,
    dly_t        load
  );
    sync_state_t nxt;
    nxt = cur;
    if (!go) begin
      // Drop straight back to offline
      nxt = SYNC_OFFLINE;
    end else begin
      case (cur)
        // Zero delay goes online on the same edge
        SYNC_OFFLINE: nxt = (load == '0) ? SYNC_ONLINE : SYNC_WAIT;
        SYNC_WAIT:    if (cnt <= dly_t'(1)) nxt = SYNC_ONLINE;
        default:      nxt = cur;
      endcase
    end
    return nxt;
  endfunction

  // Counter loads while offline, counts down while waiting
  function automatic dly_t cnt_next(sync_state_t cur, dly_t cnt, dly_t load);
    dly_t nxt;
    nxt = cnt;
    if (cur == SYNC_OFFLINE) nxt = load;
    else if (cur == SYNC_WAIT) nxt = cnt - dly_t'(1);
    return nxt;
  endfunction

  ////////////////////////////////////////
  // TX and RX sequencers
  ////////////////////////////////////////

  sync_state_t tx_state;
  sync_state_t rx_state;
  dly_t        tx_cnt;
  dly_t        rx_cnt;
  dly_t        tx_load;
  logic        rx_go;
  logic        mrk_phase;

  // TX waits for Y plus Z, wraps on overflow
  assign tx_load = dly_t'(delay_y_value + delay_z_value);

  // RX only starts once TX side is up
  assign rx_go = rx_online & tx_online_delay;

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      tx_state <= SYNC_OFFLINE;
      tx_cnt   <= '0;
    end else begin
      tx_state <= sync_next(tx_state, tx_online, tx_cnt, tx_load);
      tx_cnt   <= cnt_next(tx_state, tx_cnt, tx_load);
    end
  end

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      rx_state <= SYNC_OFFLINE;
      rx_cnt   <= '0;
    end else begin
      rx_state <= sync_next(rx_state, rx_go, rx_cnt, delay_x_value);
      rx_cnt   <= cnt_next(rx_state, rx_cnt, delay_x_value);
    end
  end

  assign tx_online_delay = (tx_state == SYNC_ONLINE);
  assign rx_online_delay = (rx_state == SYNC_ONLINE);

  ////////////////////////////////////////
  // Strobe and marker
  ////////////////////////////////////////

  // Phase held at 1 while offline, so first online word is marked
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online_delay) begin
      mrk_phase <= 1'b1;
    end else begin
      mrk_phase <= ~mrk_phase;
    end
  end

  // Persistent strobe on every online word
  assign tx_stb_bit = tx_online_delay;
  assign tx_mrk_bit = tx_online_delay & mrk_phase;

endmodule

`default_nettype wire

//--- verilog/lpif_field_pack.sv
////////////////////////////////////////
// Packs dstrm LPIF fields into a link word and unpacks ustrm fields
// One register stage in each direction
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_macros.svh"

module lpif_field_pack
  import lpif_link_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Downstream LPIF fields
  input  lp_state_t               dstrm_state,
  input  lp_protid_t              dstrm_protid,
  input  lp_data_t                dstrm_data,
  input  logic [`LL_DVALID_W-1:0] dstrm_dvalid,
  input  logic [`LL_CRC_W-1:0]    dstrm_crc,
  input  logic [`LL_CRCV_W-1:0]   dstrm_crc_valid,
  input  logic [`LL_VALID_W-1:0]  dstrm_valid,

  // Upstream LPIF fields
  output lp_state_t               ustrm_state,
  output lp_protid_t              ustrm_protid,
  output lp_data_t                ustrm_data,
  output logic [`LL_DVALID_W-1:0] ustrm_dvalid,
  output logic [`LL_CRC_W-1:0]    ustrm_crc,
  output logic [`LL_CRCV_W-1:0]   ustrm_crc_valid,
  output logic [`LL_VALID_W-1:0]  ustrm_valid,

  // Link words to and from the concatenator
  output ll_word_t                tx_word,
  input  ll_word_t                rx_word,
  input  logic                    rx_online_delay
);

  ////////////////////////////////////////
  // Downstream pack
  ////////////////////////////////////////

  // Payload only, offline gating happens at the PHY side
  always_ff @(posedge clk_wr) begin
    tx_word[`LL_STATE_LSB  +: `LL_STATE_W]  <= dstrm_state;
    tx_word[`LL_PROTID_LSB +: `LL_PROTID_W] <= dstrm_protid;
    tx_word[`LL_DATA_LSB   +: `LL_DATA_W]   <= dstrm_data;
    tx_word[`LL_DVALID_LSB +: `LL_DVALID_W] <= dstrm_dvalid;
    tx_word[`LL_CRC_LSB    +: `LL_CRC_W]    <= dstrm_crc;
    tx_word[`LL_CRCV_LSB   +: `LL_CRCV_W]   <= dstrm_crc_valid;
    tx_word[`LL_VALID_LSB  +: `LL_VALID_W]  <= dstrm_valid;
  end

  ////////////////////////////////////////
  // Upstream unpack
  ////////////////////////////////////////

  // All ustrm fields held at zero until RX side is aligned
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !rx_online_delay) begin
      ustrm_state     <= '0;
      ustrm_protid    <= '0;
      ustrm_data      <= '0;
      ustrm_dvalid    <= '0;
      ustrm_crc       <= '0;
      ustrm_crc_valid <= '0;
      ustrm_valid     <= '0;
    end else begin
      ustrm_state     <= rx_word[`LL_STATE_LSB  +: `LL_STATE_W];
      ustrm_protid    <= rx_word[`LL_PROTID_LSB +: `LL_PROTID_W];
      ustrm_data      <= rx_word[`LL_DATA_LSB   +: `LL_DATA_W];
      ustrm_dvalid    <= rx_word[`LL_DVALID_LSB +: `LL_DVALID_W];
      ustrm_crc       <= rx_word[`LL_CRC_LSB    +: `LL_CRC_W];
      // Valid qualifiers last, top of the word
      ustrm_crc_valid <= rx_word[`LL_CRCV_LSB   +: `LL_CRCV_W];
      ustrm_valid     <= rx_word[`LL_VALID_LSB  +: `LL_VALID_W];
    end
  end

endmodule

`default_nettype wire

//--- verilog/lpif_channel_concat.sv
////////////////////////////////////////
// Splits the link word over two PHY channels and rebuilds it on receive
// Adds strobe and marker bits per channel, zero while offline
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_macros.svh"

module lpif_channel_concat
  import lpif_link_pkg::*;
(
  input  logic      clk_wr,
  input  logic      rst_n,

  // Link words
  input  ll_word_t  tx_word,
  output ll_word_t  rx_word,

  // From auto-sync
  input  logic      tx_online_delay,
  input  logic      tx_stb_bit,
  input  logic      tx_mrk_bit,

  // PHY channels
  output phy_word_t tx_phy0,
  output phy_word_t tx_phy1,
  input  phy_word_t rx_phy0,
  input  phy_word_t rx_phy1
);

  ////////////////////////////////////////
  // Channel word layout
  ////////////////////////////////////////

  // Data slice low, then strobe, marker, spare bits as zero
  function automatic phy_word_t build_channel(
    logic [`LL_SLICE_W-1:0] slice,
    logic                   stb,
    logic                   mrk
  );
    phy_word_t w;
    w                   = '0;
    w[`LL_SLICE_W-1:0]  = slice;
    w[`LL_STB_BIT]      = stb;
    w[`LL_MRK_BIT]      = mrk;
    return w;
  endfunction

  ////////////////////////////////////////
  // Transmit
  ////////////////////////////////////////

  // Channel 0 gets the low half, channel 1 the high half
  always_ff @(posedge clk_wr) begin
    if (!rst_n || !tx_online_delay) begin
      tx_phy0 <= '0;
      tx_phy1 <= '0;
    end else begin
      tx_phy0 <= build_channel(tx_word[0 +: `LL_SLICE_W], tx_stb_bit, tx_mrk_bit);
      tx_phy1 <= build_channel(tx_word[`LL_SLICE_W +: `LL_SLICE_W],
                               tx_stb_bit, tx_mrk_bit);
    end
  end

  ////////////////////////////////////////
  // Receive
  ////////////////////////////////////////

  // Single clock domain, so alignment bits are not needed to rebuild
  // Only the data slices are taken, ustrm gating is done in the packer
  always_ff @(posedge clk_wr) begin
    rx_word <= {rx_phy1[`LL_SLICE_W-1:0], rx_phy0[`LL_SLICE_W-1:0]};
  end

endmodule

`default_nettype wire

//--- verilog/lpif_link_top.sv
////////////////////////////////////////
// LPIF x2 half master link top, single clock domain
// Connects auto-sync, field packer and channel concatenator
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_macros.svh"

module lpif_link_top
  import lpif_link_pkg::*;
(
  input  logic                    clk_wr,
  input  logic                    rst_n,

  // Control
  input  logic                    tx_online,
  input  logic                    rx_online,
  input  dly_t                    delay_x_value,
  input  dly_t                    delay_y_value,
  input  dly_t                    delay_z_value,

  // PHY interconnect
  output phy_word_t               tx_phy0,
  output phy_word_t               tx_phy1,
  input  phy_word_t               rx_phy0,
  input  phy_word_t               rx_phy1,

  // Downstream channel
  input  lp_state_t               dstrm_state,
  input  lp_protid_t              dstrm_protid,
  input  lp_data_t                dstrm_data,
  input  logic [`LL_DVALID_W-1:0] dstrm_dvalid,
  input  logic [`LL_CRC_W-1:0]    dstrm_crc,
  input  logic [`LL_CRCV_W-1:0]   dstrm_crc_valid,
  input  logic [`LL_VALID_W-1:0]  dstrm_valid,

  // Upstream channel
  output lp_state_t               ustrm_state,
  output lp_protid_t              ustrm_protid,
  output lp_data_t                ustrm_data,
  output logic [`LL_DVALID_W-1:0] ustrm_dvalid,
  output logic [`LL_CRC_W-1:0]    ustrm_crc,
  output logic [`LL_CRCV_W-1:0]   ustrm_crc_valid,
  output logic [`LL_VALID_W-1:0]  ustrm_valid
);

  ////////////////////////////////////////
  // Interconnect
  ////////////////////////////////////////

  ll_word_t tx_word;
  ll_word_t rx_word;
  logic     tx_online_delay;
  logic     rx_online_delay;
  logic     tx_stb_bit;
  logic     tx_mrk_bit;

  // Online delays and alignment bits
  lpif_auto_sync i_lpif_auto_sync (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .delay_z_value   (delay_z_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .tx_mrk_bit      (tx_mrk_bit)
  );

  // LPIF fields to and from link words
  lpif_field_pack i_lpif_field_pack (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .dstrm_state     (dstrm_state),
    .dstrm_protid    (dstrm_protid),
    .dstrm_data      (dstrm_data),
    .dstrm_dvalid    (dstrm_dvalid),
    .dstrm_crc       (dstrm_crc),
    .dstrm_crc_valid (dstrm_crc_valid),
    .dstrm_valid     (dstrm_valid),
    .ustrm_state     (ustrm_state),
    .ustrm_protid    (ustrm_protid),
    .ustrm_data      (ustrm_data),
    .ustrm_dvalid    (ustrm_dvalid),
    .ustrm_crc       (ustrm_crc),
    .ustrm_crc_valid (ustrm_crc_valid),
    .ustrm_valid     (ustrm_valid),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .rx_online_delay (rx_online_delay)
  );

  // Link words to and from the two PHY channels
  lpif_channel_concat i_lpif_channel_concat (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .tx_word         (tx_word),
    .rx_word         (rx_word),
    .tx_online_delay (tx_online_delay),
    .tx_stb_bit      (tx_stb_bit),
    .tx_mrk_bit      (tx_mrk_bit),
    .tx_phy0         (tx_phy0),
    .tx_phy1         (tx_phy1),
    .rx_phy0         (rx_phy0),
    .rx_phy1         (rx_phy1)
  );

endmodule

`default_nettype wire

//--- sim/lpif_link_assert.sv
////////////////////////////////////////
// Concurrent checks on the link top, attached by bind
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_macros.svh"

module lpif_link_assert
  import lpif_link_pkg::*;
(
  input logic                   clk_wr,
  input logic                   rst_n,
  input logic                   rx_online_delay,
  input logic                   tx_online_delay,
  input logic                   tx_mrk_bit,
  input logic [`LL_VALID_W-1:0] ustrm_valid,
  input phy_word_t              tx_phy0,
  input phy_word_t              tx_phy1
);

  // Count of assertion failures, summed into the run result
  int assert_fails = 0;

  // ustrm register clears the edge after rx goes offline
  ustrm_quiet: assert property (@(posedge clk_wr) disable iff (!rst_n)
    !rx_online_delay |=> (ustrm_valid == '0))
    else begin
      assert_fails++;
      $error("ustrm_valid nonzero while rx offline");
    end

  // Bits above the marker never driven
  spare_zero: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (tx_phy0[`LL_PHY_W-1:`LL_MRK_BIT+1] == '0) && (tx_phy1[`LL_PHY_W-1:`LL_MRK_BIT+1] == '0))
    else begin
      assert_fails++;
      $error("spare PHY bits nonzero");
    end

  // Marker flips every word once online
  mrk_toggle: assert property (@(posedge clk_wr) disable iff (!rst_n)
    (tx_online_delay && $past(tx_online_delay)) |-> (tx_mrk_bit != $past(tx_mrk_bit)))
    else begin
      assert_fails++;
      $error("marker did not alternate");
    end

endmodule

bind lpif_link_top lpif_link_assert i_lpif_link_assert (
  .clk_wr          (clk_wr),
  .rst_n           (rst_n),
  .rx_online_delay (rx_online_delay),
  .tx_online_delay (tx_online_delay),
  .tx_mrk_bit      (tx_mrk_bit),
  .ustrm_valid     (ustrm_valid),
  .tx_phy0         (tx_phy0),
  .tx_phy1         (tx_phy1)
);

`default_nettype wire

//--- sim/tb_lpif_link.sv
////////////////////////////////////////
// Testbench for the LPIF x2 master link with tx_phy looped to rx_phy
// Top module tb_lpif_link, compiled from tb.f
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none
`include "lpif_link_macros.svh"

module tb_lpif_link
  import lpif_link_pkg::*;
();

  localparam int DLY_X        = 2;
  localparam int DLY_Y        = 3;
  localparam int DLY_Z        = 4;
  localparam int WAIT_LIMIT   = 64;
  localparam int LAYOUT_WORDS = 40;
  localparam int LOOP_WORDS   = 200;

  // Conditions for wait_for
  localparam int W_STROBE     = 0;
  localparam int W_USTRM_UP   = 1;
  localparam int W_USTRM_ZERO = 2;
  localparam int W_PHY_ZERO   = 3;

  logic       clk_wr = 1'b0;
  logic       rst_n;
  logic       tx_online;
  logic       rx_online;
  dly_t       delay_x_value;
  dly_t       delay_y_value;
  dly_t       delay_z_value;
  phy_word_t  tx_phy0;
  phy_word_t  tx_phy1;
  phy_word_t  rx_phy0 = '0;
  phy_word_t  rx_phy1 = '0;
  lp_state_t  dstrm_state;
  lp_protid_t dstrm_protid;
  lp_data_t   dstrm_data;
  logic [1:0] dstrm_dvalid;
  logic [3:0] dstrm_crc;
  logic [1:0] dstrm_crc_valid;
  logic [1:0] dstrm_valid;
  lp_state_t  ustrm_state;
  lp_protid_t ustrm_protid;
  lp_data_t   ustrm_data;
  logic [1:0] ustrm_dvalid;
  logic [3:0] ustrm_crc;
  logic [1:0] ustrm_crc_valid;
  logic [1:0] ustrm_valid;

  // Scoreboard state
  int          errors;
  int          checks;
  int          cyc;
  int          on_cyc;
  logic        chk_phy;
  logic        chk_loop;
  logic [31:0] rng;
  ll_word_t    hist [0:15];

  always #5 clk_wr = ~clk_wr;

  lpif_link_top i_lpif_link_top (.*);

  // Die-to-die wire as one register per channel
  always @(posedge clk_wr) begin
    rx_phy0 <= tx_phy0;
    rx_phy1 <= tx_phy1;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Link word with state at bit 0 and valid on top
  function automatic ll_word_t pack_fields(lp_state_t st, lp_protid_t pid, lp_data_t data,
      logic [1:0] dv, logic [3:0] crc, logic [1:0] crcv, logic [1:0] vld);
    return {vld, crcv, crc, dv, data, pid, st};
  endfunction

  // Expected {ch1, ch0} for one word
  function automatic logic [159:0] ref_channels(ll_word_t w, logic stb, logic mrk);
    phy_word_t ch0;
    phy_word_t ch1;
    ch0 = {3'b000, mrk, stb, w[74:0]};
    ch1 = {3'b000, mrk, stb, w[149:75]};
    return {ch1, ch0};
  endfunction

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Fields sampled at each edge and indexed by edge count
  always @(posedge clk_wr) begin
    hist[cyc & 15] <= pack_fields(dstrm_state, dstrm_protid, dstrm_data, dstrm_dvalid,
                                  dstrm_crc, dstrm_crc_valid, dstrm_valid);
    cyc <= cyc + 1;
  end

  task automatic compare_field(string name, logic [149:0] exp, logic [149:0] got);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  ////////////////////////////////////////
  // Compare process
  ////////////////////////////////////////

  // tx_phy lags dstrm by 2 edges and ustrm by 5
  always @(negedge clk_wr) begin : compare
    logic [159:0] exp_phy;
    ll_word_t     exp_word;
    if (chk_phy) begin
      // Marker set on first online word and on every second one after
      exp_phy = ref_channels(hist[(cyc - 2) & 15], 1'b1, ((cyc - on_cyc) % 2) == 0);
      compare_field("tx_phy0", exp_phy[79:0], tx_phy0);
      compare_field("tx_phy1", exp_phy[159:80], tx_phy1);
    end
    if (chk_loop) begin
      exp_word = hist[(cyc - 5) & 15];
      compare_field("ustrm_state", exp_word[7:0], ustrm_state);
      compare_field("ustrm_protid", exp_word[11:8], ustrm_protid);
      compare_field("ustrm_data", exp_word[139:12], ustrm_data);
      compare_field("ustrm_dvalid", exp_word[141:140], ustrm_dvalid);
      compare_field("ustrm_crc", exp_word[145:142], ustrm_crc);
      compare_field("ustrm_crc_valid", exp_word[147:146], ustrm_crc_valid);
      compare_field("ustrm_valid", exp_word[149:148], ustrm_valid);
    end
  end

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  task automatic drive_random();
    logic [31:0] r [0:5];
    next_cycle();
    for (int i = 0; i < 6; i++) begin
      rng  = lcg_next(rng);
      r[i] = rng;
    end
    dstrm_data      = {r[0], r[1], r[2], r[3]};
    // Upper LCG bits for the narrow fields
    dstrm_state     = r[4][31:24];
    dstrm_protid    = r[4][23:20];
    dstrm_dvalid    = r[4][19:18];
    dstrm_crc       = r[5][31:28];
    dstrm_crc_valid = r[5][27:26];
    dstrm_valid     = r[5][25:24];
  endtask

  function automatic logic cond_met(int what);
    case (what)
      W_STROBE:     return tx_phy0[`LL_STB_BIT] === 1'b1;
      W_USTRM_UP:   return ustrm_valid !== 2'b00;
      W_USTRM_ZERO: return pack_fields(ustrm_state, ustrm_protid, ustrm_data, ustrm_dvalid,
                                       ustrm_crc, ustrm_crc_valid, ustrm_valid) === '0;
      default:      return {tx_phy1, tx_phy0} === '0;
    endcase
  endfunction

  // Polls at the falling edge and gives up after WAIT_LIMIT cycles
  task automatic wait_for(int what, string label);
    int n;
    n = 0;
    @(negedge clk_wr);
    while (!cond_met(what) && n < WAIT_LIMIT) begin
      @(negedge clk_wr);
      n++;
    end
    if (!cond_met(what)) begin
      errors++;
      $display("Timeout after %0d cycles waiting for %s", n, label);
    end
  endtask

  task automatic report_test(int num, string name, int errs);
    $display("Test %0d %s: %0d errors", num, name, errs);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial begin
    int base;
    int t_err;
    rst_n           = 1'b0;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    delay_x_value   = dly_t'(DLY_X);
    delay_y_value   = dly_t'(DLY_Y);
    delay_z_value   = dly_t'(DLY_Z);
    dstrm_state     = '0;
    dstrm_protid    = '0;
    dstrm_data      = '0;
    dstrm_dvalid    = '0;
    dstrm_crc       = '0;
    dstrm_crc_valid = '0;
    dstrm_valid     = '0;
    errors          = 0;
    checks          = 0;
    cyc             = 0;
    on_cyc          = 0;
    chk_phy         = 1'b0;
    chk_loop        = 1'b0;
    rng             = 32'd4225;
    repeat (5) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Everything quiet out of reset
    t_err = errors;
    @(negedge clk_wr);
    compare_field("tx_phy0", '0, tx_phy0);
    compare_field("tx_phy1", '0, tx_phy1);
    compare_field("ustrm_*", '0, pack_fields(ustrm_state, ustrm_protid, ustrm_data,
                  ustrm_dvalid, ustrm_crc, ustrm_crc_valid, ustrm_valid));
    report_test(1, "reset state", errors - t_err);

    // Constant word with valid set and both sides brought up together
    t_err = errors;
    next_cycle();
    dstrm_state  = 8'h5a;
    dstrm_protid = 4'h3;
    dstrm_data   = {4{32'hc0de_1234}};
    dstrm_valid  = 2'b11;
    tx_online    = 1'b1;
    rx_online    = 1'b1;
    // Sampled next edge then Y+Z wait and the concat register
    on_cyc = cyc + DLY_Y + DLY_Z + 2;
    wait_for(W_STROBE, "tx strobe");
    if (cyc != on_cyc) begin
      errors++;
      $display("[FAIL] %0t tx_phy0 strobe edge expected %0d got %0d", $time, on_cyc, cyc);
    end
    // RX first sees TX online on the expected strobe edge
    // X cycles of wait plus the ustrm register follow
    wait_for(W_USTRM_UP, "ustrm_valid");
    if (cyc != on_cyc + DLY_X + 1) begin
      errors++;
      $display("[FAIL] %0t ustrm_valid rise edge expected %0d got %0d", $time,
               on_cyc + DLY_X + 1, cyc);
    end
    report_test(2, "online delays", errors - t_err);

    t_err = errors;
    drive_random();
    chk_phy = 1'b1;
    repeat (LAYOUT_WORDS + 1) drive_random();
    report_test(3, "channel layout", errors - t_err);

    t_err = errors;
    drive_random();
    chk_loop = 1'b1;
    repeat (LOOP_WORDS + 4) drive_random();
    report_test(4, "loopback", errors - t_err);

    // RX dropped first and TX after
    t_err = errors;
    next_cycle();
    chk_phy   = 1'b0;
    chk_loop  = 1'b0;
    rx_online = 1'b0;
    base      = cyc;
    wait_for(W_USTRM_ZERO, "ustrm clear");
    if (cyc - base > 2) begin
      errors++;
      $display("[FAIL] %0t ustrm_* clear cycles expected <= 2 got %0d", $time, cyc - base);
    end
    next_cycle();
    tx_online = 1'b0;
    base      = cyc;
    wait_for(W_PHY_ZERO, "tx_phy clear");
    if (cyc - base > 2) begin
      errors++;
      $display("[FAIL] %0t tx_phy0 clear cycles expected <= 2 got %0d", $time, cyc - base);
    end
    report_test(5, "dropping online", errors - t_err);

    errors = errors + i_lpif_link_top.i_lpif_link_assert.assert_fails;
    $display("Tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verilog
verilog/lpif_link_pkg.sv
verilog/lpif_auto_sync.sv
verilog/lpif_field_pack.sv
verilog/lpif_channel_concat.sv
verilog/lpif_link_top.sv
sim/lpif_link_assert.sv
sim/tb_lpif_link.sv
